// ==== mdpt_wrapper.f ====
rtl/mdpt_pkg.sv
rtl/mdpt_wr_if.sv
rtl/mdpt_index.sv
rtl/mdpt_array.sv
rtl/mdpt_resp_bypass.sv
rtl/mdpt.sv
rtl/mdpt_wrapper.sv
tb/tb_clock.sv
tb/tb_mdpt_wrapper.sv

// ==== rtl/mdpt.sv ====
/*
 * mdp table core, one cycle from request to response
 * no response strobe, response holds while no read arrives
 */
module mdpt (
    input  logic                 CLK,
    input  logic                 nRST,

    // read request
    input  logic                 read_req_valid,
    input  mdpt_pkg::fetch_idx_t read_req_fetch_idx,
    input  mdpt_pkg::asid_t      read_req_asid,

    // read response
    output mdpt_pkg::mdpt_set_t  read_resp_mdp_by_lane,

    // update
    input  logic                 update_valid,
    input  mdpt_pkg::pc38_t      update_pc38,
    input  mdpt_pkg::asid_t      update_asid,
    input  mdpt_pkg::mdp_t       update_mdp
);
    import mdpt_pkg::*;

    // --------------------------------------------------
    // internal links
    logic       rd_valid;
    fetch_idx_t rd_set;
    mdpt_set_t  arr_set;

    // decoded write, shared by storage and bypass
    mdpt_wr_if wr_bus ();

    // --------------------------------------------------
    // input side
    mdpt_index index0 (
        .read_req_valid     (read_req_valid),
        .read_req_fetch_idx (read_req_fetch_idx),
        .read_req_asid      (read_req_asid),
        .update_valid       (update_valid),
        .update_pc38        (update_pc38),
        .update_asid        (update_asid),
        .update_mdp         (update_mdp),
        .rd_valid           (rd_valid),
        .rd_set             (rd_set),
        .wr                 (wr_bus.src)
    );

    // storage
    mdpt_array array0 (
        .CLK     (CLK),
        .nRST    (nRST),
        .rd_valid(rd_valid),
        .rd_set  (rd_set),
        .wr      (wr_bus.dst),
        .arr_set (arr_set)
    );

    // output side
    mdpt_resp_bypass bypass0 (
        .CLK     (CLK),
        .nRST    (nRST),
        .rd_valid(rd_valid),
        .rd_set  (rd_set),
        .wr      (wr_bus.dst),
        .arr_set (arr_set),
        .resp    (read_resp_mdp_by_lane)
    );

endmodule

// ==== rtl/mdpt_array.sv ====
/*
 * 64 x 8 mdp byte storage, one lane write and one set read per cycle
 * read returns contents from before a same-edge write
 * all entries clear on reset
 */
module mdpt_array (
    input  logic                 CLK,
    input  logic                 nRST,

    // set read
    input  logic                 rd_valid,
    input  mdpt_pkg::fetch_idx_t rd_set,

    // lane write
    mdpt_wr_if.dst               wr,

    // registered set out, holds between reads
    output mdpt_pkg::mdpt_set_t  arr_set
);
    import mdpt_pkg::*;

    // --------------------------------------------------
    // storage
    mdpt_set_t table_q [MDPT_SETS];

    // next arr_set value, muxed ahead of the flop
    mdpt_set_t rd_data;

    // full set out of the table, pre-write contents
    assign rd_data = table_q[rd_set];

    // --------------------------------------------------
    // write port
    // only the addressed lane of the addressed set changes
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < MDPT_SETS; s++) begin
                table_q[s] <= '0;
            end
        end else begin
            if (wr.wr_valid) begin
                table_q[wr.wr_set][wr.wr_lane] <= wr.wr_mdp;
            end
        end
    end

    // --------------------------------------------------
    // read port
    // nonblocking so a same-edge write is not visible here,
    // the response bypass covers that case
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            arr_set <= '0;
        end else begin
            // hold last set while idle
            if (rd_valid) begin
                arr_set <= rd_data;
            end
        end
    end

endmodule

// ==== rtl/mdpt_index.sv ====
/*
 * request decode for the mdp table, purely combinational
 * update address bits above the fetch index are ignored
 */
module mdpt_index (
    // read request
    input  logic                 read_req_valid,
    input  mdpt_pkg::fetch_idx_t read_req_fetch_idx,
    input  mdpt_pkg::asid_t      read_req_asid,

    // update request
    input  logic                 update_valid,
    input  mdpt_pkg::pc38_t      update_pc38,
    input  mdpt_pkg::asid_t      update_asid,
    input  mdpt_pkg::mdp_t       update_mdp,

    // decoded read
    output logic                 rd_valid,
    output mdpt_pkg::fetch_idx_t rd_set,

    // decoded write
    mdpt_wr_if.src               wr
);
    import mdpt_pkg::*;

    // update address split into block and lane
    fetch_idx_t upd_fetch_idx;
    lane_t      upd_lane;

    // --------------------------------------------------
    // read side
    assign rd_valid = read_req_valid;
    // read index already arrives as a fetch block index
    assign rd_set   = mdpt_set_hash(read_req_fetch_idx, read_req_asid);

    // --------------------------------------------------
    // update side
    // low bits pick the lane, next field is the fetch block
    assign upd_lane      = update_pc38[MDPT_LANE_BITS-1:0];
    assign upd_fetch_idx = update_pc38[MDPT_LANE_BITS +: MDPT_SET_BITS];

    // same hash as the read so both hit the same set
    assign wr.wr_valid = update_valid;
    assign wr.wr_set   = mdpt_set_hash(upd_fetch_idx, update_asid);
    assign wr.wr_lane  = upd_lane;
    assign wr.wr_mdp   = update_mdp;

endmodule

// ==== rtl/mdpt_pkg.sv ====
/*
 * shared sizes, field types and set hash for the mdp table
 * table is direct-mapped and untagged, so aliasing is expected
 * pc38 layout: bits 2..0 lane, bits 8..3 fetch index, rest unused
 */
package mdpt_pkg;

    // --------------------------------------------------
    // table geometry
    localparam int MDPT_LANES     = 8;
    localparam int MDPT_SETS      = 64;
    localparam int MDPT_LANE_BITS = $clog2(MDPT_LANES);
    localparam int MDPT_SET_BITS  = $clog2(MDPT_SETS);

    // field widths
    localparam int ASID_BITS = 9;
    localparam int PC_BITS   = 38;
    localparam int MDP_BITS  = 8;

    // --------------------------------------------------
    // field types
    // fetch block index doubles as the set index
    typedef logic [MDPT_SET_BITS-1:0]  fetch_idx_t;
    typedef logic [MDPT_LANE_BITS-1:0] lane_t;
    typedef logic [ASID_BITS-1:0]      asid_t;
    typedef logic [PC_BITS-1:0]        pc38_t;
    typedef logic [MDP_BITS-1:0]       mdp_t;

    // one fetch block worth of predictions, indexed by lane
    typedef mdp_t [MDPT_LANES-1:0] mdpt_set_t;

    // --------------------------------------------------
    // set hash
    // fetch index xor low asid bits xor folded high asid bits
    function automatic fetch_idx_t mdpt_set_hash(
        input fetch_idx_t fetch_idx,
        input asid_t      asid
    );
        fetch_idx_t asid_lo;
        fetch_idx_t asid_hi;
        asid_lo = asid[MDPT_SET_BITS-1:0];
        // upper asid bits, zero-extended to set width
        asid_hi = fetch_idx_t'(asid[ASID_BITS-1:MDPT_SET_BITS]);
        return fetch_idx ^ asid_lo ^ asid_hi;
    endfunction

endpackage

// ==== rtl/mdpt_resp_bypass.sv ====
/*
 * forwards an update that lands at the same edge as a read
 * of the same set into that read's response
 * output is combinational after the hit register
 */
module mdpt_resp_bypass (
    input  logic                 CLK,
    input  logic                 nRST,

    // read being launched this cycle
    input  logic                 rd_valid,
    input  mdpt_pkg::fetch_idx_t rd_set,

    // write being applied this cycle
    mdpt_wr_if.dst               wr,

    // registered set from storage
    input  mdpt_pkg::mdpt_set_t  arr_set,

    // response to the core output
    output mdpt_pkg::mdpt_set_t  resp
);
    import mdpt_pkg::*;

    // same-set collision between write and read
    logic  wr_hit;

    // captured forward info
    logic  hit_q;
    lane_t hit_lane_q;
    mdp_t  hit_mdp_q;

    assign wr_hit = wr.wr_valid && (wr.wr_set == rd_set);

    // --------------------------------------------------
    // hit flag, updated only when a read launches
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            hit_q <= 1'b0;
        end else if (rd_valid) begin
            hit_q <= wr_hit;
        end
    end

    // forwarded lane and byte, meaningless unless hit_q
    always_ff @(posedge CLK) begin
        if (rd_valid && wr_hit) begin
            hit_lane_q <= wr.wr_lane;
            hit_mdp_q  <= wr.wr_mdp;
        end
    end

    // --------------------------------------------------
    // overlay the forwarded byte onto the array set
    always_comb begin
        resp = arr_set;
        if (hit_q) begin
            resp[hit_lane_q] = hit_mdp_q;
        end
    end

endmodule

// ==== rtl/mdpt_wr_if.sv ====
/*
 * one decoded table write per cycle, no handshake
 * wr_valid is a single-cycle strobe and the write always lands
 */
interface mdpt_wr_if;
    import mdpt_pkg::*;

    // write strobe
    logic       wr_valid;
    // hashed set and lane within the set
    fetch_idx_t wr_set;
    lane_t      wr_lane;
    // new prediction byte
    mdp_t       wr_mdp;

    // driven by the index stage
    modport src (
        output wr_valid, wr_set, wr_lane, wr_mdp
    );

    // seen by storage and response bypass
    modport dst (
        input wr_valid, wr_set, wr_lane, wr_mdp
    );

endinterface

// ==== rtl/mdpt_wrapper.sv ====
/*
 * register ring around the mdp table core
 * a read sampled at edge N shows on the output after edge N+2
 * and reflects all updates sampled up to and including edge N
 */
module mdpt_wrapper (
    input  logic                 CLK,
    input  logic                 nRST,

    // read request stage
    input  logic                 next_read_req_valid,
    input  mdpt_pkg::fetch_idx_t next_read_req_fetch_idx,
    input  mdpt_pkg::asid_t      next_read_req_asid,

    // read response stage
    output mdpt_pkg::mdpt_set_t  last_read_resp_mdp_by_lane,

    // update
    input  logic                 next_update_valid,
    input  mdpt_pkg::pc38_t      next_update_pc38,
    input  mdpt_pkg::asid_t      next_update_asid,
    input  mdpt_pkg::mdp_t       next_update_mdp
);
    import mdpt_pkg::*;

    // --------------------------------------------------
    // core side of the input and output flops
    logic       read_req_valid;
    fetch_idx_t read_req_fetch_idx;
    asid_t      read_req_asid;

    mdpt_set_t  read_resp_mdp_by_lane;

    logic       update_valid;
    pc38_t      update_pc38;
    asid_t      update_asid;
    mdp_t       update_mdp;

    // --------------------------------------------------
    mdpt wrapped_module (
        .CLK                   (CLK),
        .nRST                  (nRST),
        .read_req_valid        (read_req_valid),
        .read_req_fetch_idx    (read_req_fetch_idx),
        .read_req_asid         (read_req_asid),
        .read_resp_mdp_by_lane (read_resp_mdp_by_lane),
        .update_valid          (update_valid),
        .update_pc38           (update_pc38),
        .update_asid           (update_asid),
        .update_mdp            (update_mdp)
    );

    // --------------------------------------------------
    // boundary registers, isolate core timing
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            read_req_valid             <= 1'b0;
            read_req_fetch_idx         <= '0;
            read_req_asid              <= '0;
            last_read_resp_mdp_by_lane <= '0;
            update_valid               <= 1'b0;
            update_pc38                <= '0;
            update_asid                <= '0;
            update_mdp                 <= '0;
        end else begin
            // request side
            read_req_valid             <= next_read_req_valid;
            read_req_fetch_idx         <= next_read_req_fetch_idx;
            read_req_asid              <= next_read_req_asid;
            // response side
            last_read_resp_mdp_by_lane <= read_resp_mdp_by_lane;
            // update side
            update_valid               <= next_update_valid;
            update_pc38                <= next_update_pc38;
            update_asid                <= next_update_asid;
            update_mdp                 <= next_update_mdp;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mdp table testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=tb_mdpt_wrapper

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" -Mdir "$OBJ" -f mdpt_wrapper.f
if [ $? -ne 0 ]; then
    echo "run_sim: verilator build failed"
    exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
    echo "run_sim: PASS"
    exit 0
fi
echo "run_sim: FAIL"
exit 1

// ==== tb/tb_clock.sv ====
/*
 * clock and reset source for the testbench
 * reset released by a nonblocking write at a rising edge
 */
module tb_clock (
    output logic CLK,
    output logic nRST
);
    localparam int HALF_PERIOD = 20;
    localparam int RST_CYCLES  = 5;

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    // active low reset for the first few edges
    initial begin
        nRST = 1'b0;
        repeat (RST_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

// ==== tb/tb_mdpt_wrapper.sv ====
/*
 * testbench for the mdp table wrapper
 * model applies updates and snapshots reads at the DUT sampling edge
 * output compared at every falling edge so idle cycles also check hold
 */
module tb_mdpt_wrapper;
    import mdpt_pkg::*;

    // --------------------------------------------------
    // test lengths in cycles set the run limit
    localparam int RST_CYC    = 5;
    localparam int DRAIN_CYC  = 6;
    localparam int LEN_RESET  = 8;
    localparam int LEN_WR_RD  = 14;
    localparam int LEN_BYPASS = 10;
    localparam int LEN_ASID   = 10;
    localparam int LEN_B2B    = 300;
    localparam int LEN_HOLD   = 20;
    localparam int NUM_TESTS  = 6;
    localparam int MAX_CYC    = RST_CYC + LEN_RESET + LEN_WR_RD + LEN_BYPASS + LEN_ASID
                                + LEN_B2B + LEN_HOLD + NUM_TESTS * DRAIN_CYC + 50;

    logic       CLK;
    logic       nRST;
    logic       next_read_req_valid;
    fetch_idx_t next_read_req_fetch_idx;
    asid_t      next_read_req_asid;
    logic       next_update_valid;
    pc38_t      next_update_pc38;
    asid_t      next_update_asid;
    mdp_t       next_update_mdp;
    mdpt_set_t  last_read_resp_mdp_by_lane;

    // reference table and reads in flight
    mdpt_set_t model_tbl [MDPT_SETS];
    int        pend_due [$];
    mdpt_set_t pend_set [$];
    mdpt_set_t exp_out = '0;

    int cyc          = 0;
    int check_cnt    = 0;
    int fail_cnt     = 0;
    int same_set_cnt = 0;
    int test_pass    = 0;
    int test_fail    = 0;
    int base_checks  = 0;
    int base_fails   = 0;

    // folds 0, 0, 1, 0 so random traffic mixes aliasing and distinct sets
    asid_t asid_pool [4] = '{9'h000, 9'h041, 9'h001, 9'h1c7};

    tb_clock clk0 (
        .CLK  (CLK),
        .nRST (nRST)
    );

    mdpt_wrapper dut0 (
        .CLK                        (CLK),
        .nRST                       (nRST),
        .next_read_req_valid        (next_read_req_valid),
        .next_read_req_fetch_idx    (next_read_req_fetch_idx),
        .next_read_req_asid         (next_read_req_asid),
        .last_read_resp_mdp_by_lane (last_read_resp_mdp_by_lane),
        .next_update_valid          (next_update_valid),
        .next_update_pc38           (next_update_pc38),
        .next_update_asid           (next_update_asid),
        .next_update_mdp            (next_update_mdp)
    );

    // --------------------------------------------------
    // reference model sees the inputs the DUT samples at this edge
    always @(posedge CLK) begin : model_step
        fetch_idx_t upd_set;
        fetch_idx_t rd_set;
        cyc = cyc + 1;
        if (nRST !== 1'b1) begin
            for (int s = 0; s < MDPT_SETS; s++) begin
                model_tbl[s] = '0;
            end
            pend_due.delete();
            pend_set.delete();
        end else begin
            // pc bits 8..3 are the fetch index and bits 2..0 the lane
            upd_set = mdpt_set_hash(next_update_pc38[8:3], next_update_asid);
            rd_set  = mdpt_set_hash(next_read_req_fetch_idx, next_read_req_asid);
            if (next_update_valid) begin
                model_tbl[upd_set][next_update_pc38[2:0]] = next_update_mdp;
            end
            // snapshot taken after this edge's update
            if (next_read_req_valid) begin
                pend_due.push_back(cyc + 2);
                pend_set.push_back(model_tbl[rd_set]);
                if (next_update_valid && upd_set == rd_set) begin
                    same_set_cnt++;
                end
            end
        end
    end

    // output check mid cycle where the response is stable
    always @(negedge CLK) begin : out_check
        if (nRST !== 1'b1) begin
            exp_out = '0;
        end else begin
            if (pend_due.size() != 0 && pend_due[0] == cyc) begin
                void'(pend_due.pop_front());
                exp_out = pend_set.pop_front();
            end
            check_cnt++;
            assert (last_read_resp_mdp_by_lane === exp_out) else begin
                $display("Mismatch last_read_resp_mdp_by_lane: expected %h, got %h at cycle %0d",
                         exp_out, last_read_resp_mdp_by_lane, cyc);
                fail_cnt++;
            end
        end
    end

    always @(negedge CLK) begin
        if (cyc > MAX_CYC) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYC);
            $display("Something failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // stimulus helpers
    task automatic drive_cycle(input logic rd_v, input fetch_idx_t rd_f, input asid_t rd_a,
                               input logic up_v, input pc38_t up_pc, input asid_t up_a,
                               input mdp_t up_m);
        @(posedge CLK);
        next_read_req_valid     <= rd_v;
        next_read_req_fetch_idx <= rd_f;
        next_read_req_asid      <= rd_a;
        next_update_valid       <= up_v;
        next_update_pc38        <= up_pc;
        next_update_asid        <= up_a;
        next_update_mdp         <= up_m;
    endtask

    task automatic read_only(input fetch_idx_t f, input asid_t a);
        drive_cycle(1'b1, f, a, 1'b0, '0, '0, '0);
    endtask

    task automatic update_only(input pc38_t pc, input asid_t a, input mdp_t m);
        drive_cycle(1'b0, '0, '0, 1'b1, pc, a, m);
    endtask

    // random upper address bits are ignored by the table
    function automatic pc38_t make_pc(input fetch_idx_t f, input lane_t l);
        return {29'($urandom), f, l};
    endfunction

    // wait until every queued read has been compared
    task automatic drain_pipe();
        drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, '0);
        @(negedge CLK);
        while (pend_due.size() != 0) begin
            @(negedge CLK);
        end
        @(posedge CLK);
    endtask

    task automatic check_hash(input fetch_idx_t f, input asid_t a, input fetch_idx_t exp_set);
        fetch_idx_t got;
        got = mdpt_set_hash(f, a);
        check_cnt++;
        assert (got == exp_set) else begin
            $display("Mismatch set hash for asid %h: expected %h, got %h", a, exp_set, got);
            fail_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        int checks;
        int fails;
        checks = check_cnt - base_checks;
        fails  = fail_cnt - base_fails;
        if (fails == 0) begin
            test_pass++;
            $display("test %s: %0d checks, no errors", name, checks);
        end else begin
            test_fail++;
            $display("test %s: %0d checks, %0d errors", name, checks, fails);
        end
        base_checks = check_cnt;
        base_fails  = fail_cnt;
    endtask

    // --------------------------------------------------
    initial begin : stimulus
        fetch_idx_t f;
        fetch_idx_t uf;
        asid_t      a;
        asid_t      ua;
        logic       uv;
        int         same_base;
        void'($urandom(32'haa63fb65));
        next_read_req_valid     <= 1'b0;
        next_read_req_fetch_idx <= '0;
        next_read_req_asid      <= '0;
        next_update_valid       <= 1'b0;
        next_update_pc38        <= '0;
        next_update_asid        <= '0;
        next_update_mdp         <= '0;
        wait (nRST === 1'b1);

        // reads straight out of reset
        for (int i = 0; i < LEN_RESET; i++) begin
            read_only(fetch_idx_t'($urandom), asid_t'($urandom));
        end
        drain_pipe();
        end_test("reset");

        // fill all lanes of one set then read it and its neighbours
        f = 6'h15;
        a = 9'h0a3;
        for (int l = 0; l < MDPT_LANES; l++) begin
            update_only(make_pc(f, lane_t'(l)), a, mdp_t'(8'h10 + l * 8'h21));
        end
        read_only(f, a);
        for (int k = 1; k < 4; k++) begin
            read_only(f + fetch_idx_t'(k), a);
        end
        drain_pipe();
        end_test("write_read");

        // update and read of the same set at the same edge
        f = 6'h07;
        a = 9'h10c;
        for (int l = 0; l < 6; l++) begin
            drive_cycle(1'b1, f, a, 1'b1, make_pc(f, lane_t'(l)), a, mdp_t'($urandom));
        end
        drive_cycle(1'b1, f ^ 6'h01, a, 1'b1, make_pc(f, 3'd7), a, 8'hc3);
        read_only(f, a);
        drain_pipe();
        end_test("bypass");

        // 0x041 folds like 0x000 while 0x001 does not
        f = 6'h2a;
        check_hash(f, 9'h041, 6'h2a);
        check_hash(f, 9'h001, 6'h2b);
        update_only(make_pc(f, 3'd3), 9'h000, 8'h5a);
        read_only(f, 9'h041);
        read_only(f, 9'h001);
        drive_cycle(1'b1, f, 9'h001, 1'b1, make_pc(f, 3'd3), 9'h001, 8'ha5);
        read_only(f, 9'h000);
        read_only(f, 9'h041);
        drain_pipe();
        end_test("asid_hash");

        // a read every cycle over a few sets with random updates in between
        same_base = same_set_cnt;
        for (int i = 0; i < LEN_B2B; i++) begin
            f  = fetch_idx_t'($urandom % 8);
            a  = asid_pool[2'($urandom % 4)];
            uf = fetch_idx_t'($urandom % 8);
            ua = asid_pool[2'($urandom % 4)];
            uv = 1'($urandom % 2);
            drive_cycle(1'b1, f, a, uv, make_pc(uf, lane_t'($urandom)), ua, mdp_t'($urandom));
        end
        drain_pipe();
        check_cnt++;
        assert (same_set_cnt > same_base) else begin
            $display("random traffic never put an update and a read on the same set");
            fail_cnt++;
        end
        end_test("back_to_back");

        // last read carries a forwarded byte in lane 2
        // output must hold while updates stream into that set
        f = 6'h15;
        a = 9'h0a3;
        drive_cycle(1'b1, f, a, 1'b1, make_pc(f, 3'd2), a, 8'h3c);
        for (int i = 0; i < 10; i++) begin
            update_only(make_pc(f, lane_t'(i)), a, mdp_t'($urandom));
        end
        drain_pipe();
        read_only(f, a);
        drain_pipe();
        end_test("hold");

        $display("tests %0d passed, %0d failed, checks %0d, errors %0d",
                 test_pass, test_fail, check_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
